//--- verilog.f
+incdir+include
src/playground_pkg.sv
src/bus_decode.sv
src/word_ram.sv
src/io_regs.sv
src/interval_timer.sv
src/led_sdm.sv
src/periph_top.sv
verif/tb_periph.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the verdict
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_periph -o tb_periph_sim

./obj_dir/tb_periph_sim | tee sim.log

if grep -q "Everything OK" sim.log
then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi

//--- include/tb_checks.svh
/*
   Compare and bus access tasks for the testbench, included inside its module.
   They expect clk, mem_req and mem_rdata in the including scope, are called
   1 ns after a rising edge and return 1 ns after one. Any mismatch ends the run.
*/
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Common failure path, values shown in hex
task automatic fail_check(input string name, input playground_pkg::word_t got,
                          input playground_pkg::word_t exp);
   $display("error %s got %h expected %h", name, got, exp);
   $display("Something failed");
   $fatal(1);
endtask

task automatic check_word(input string name, input playground_pkg::word_t got,
                          input playground_pkg::word_t exp);
   if (got !== exp) fail_check(name, got, exp);   // Also catches X and Z
endtask

task automatic check_gpio(input string name, input logic [playground_pkg::GPIO_W-1:0] got,
                          input logic [playground_pkg::GPIO_W-1:0] exp);
   if (got !== exp) fail_check(name, playground_pkg::word_t'(got), playground_pkg::word_t'(exp));
endtask

task automatic check_rgb(input string name, input playground_pkg::rgb_t got,
                         input playground_pkg::rgb_t exp);
   if (got !== exp) fail_check(name, playground_pkg::word_t'(got), playground_pkg::word_t'(exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
   if (got !== exp) fail_check(name, playground_pkg::word_t'(got), playground_pkg::word_t'(exp));
endtask

// One write cycle, mask non-zero
task automatic bus_write(input playground_pkg::word_t addr, input playground_pkg::word_t data,
                         input logic [playground_pkg::MASK_W-1:0] mask);
   mem_req.addr  = addr;
   mem_req.wdata = data;
   mem_req.wmask = mask;
   mem_req.rstrb = 1'b0;
   @(posedge clk);
   #1;
   mem_req.wmask = '0;
endtask

// Strobe cycle, then address held while the data comes back
task automatic bus_read(input playground_pkg::word_t addr, output playground_pkg::word_t data);
   mem_req.addr  = addr;
   mem_req.wmask = '0;
   mem_req.rstrb = 1'b1;
   @(posedge clk);
   #1;
   mem_req.rstrb = 1'b0;
   data = mem_rdata;
   @(posedge clk);
   #1;
endtask

`endif

//--- verif/tb_periph.sv
/*
   Testbench for periph_top. Stands in for the CPU on the native memory bus,
   applies a stimulus table built from a scoreboard model of the RAM and GPIO
   rules, then runs the timer wrap and LED modulator checks cycle by cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_periph;

   localparam int SEED         = 65837;
   localparam int RESET_CYCLES = 16;
   localparam int TIMER_WAIT   = 24;    // Cycles spent in the timer checks
   localparam int LED_WAIT     = 120;   // Cycles spent in the LED checks
   localparam int TICKS_GAP    = 5;     // Ticks written this far below the wrap

   localparam playground_pkg::word_t IO_BASE       = 32'h4000_0000;
   localparam playground_pkg::word_t PORT_IN_ADDR  = IO_BASE | (1 << playground_pkg::IO_BIT_PORT_IN);
   localparam playground_pkg::word_t PORT_OUT_ADDR = IO_BASE | (1 << playground_pkg::IO_BIT_PORT_OUT);
   localparam playground_pkg::word_t PORT_DIR_ADDR = IO_BASE | (1 << playground_pkg::IO_BIT_PORT_DIR);
   localparam playground_pkg::word_t LEDS_ADDR     = IO_BASE | (1 << playground_pkg::IO_BIT_LEDS);
   localparam playground_pkg::word_t SDM_RED_ADDR  = IO_BASE | (1 << playground_pkg::IO_BIT_SDM_RED);
   localparam playground_pkg::word_t TICKS_ADDR    = IO_BASE | (1 << playground_pkg::IO_BIT_TICKS);
   localparam playground_pkg::word_t RELOAD_ADDR   = IO_BASE | (1 << playground_pkg::IO_BIT_RELOAD);

   typedef enum logic [1:0] {
      OP_WRITE,
      OP_READ,
      OP_PINS,   // Compare gpio_out and gpio_dir, no bus cycle
      OP_WAIT
   } tb_op_e;

   typedef struct packed {
      tb_op_e                                op;
      playground_pkg::word_t                 addr;
      playground_pkg::word_t                 data;
      logic [playground_pkg::MASK_W-1:0]     mask;
      logic [playground_pkg::GPIO_W-1:0]     gpio;       // gpio_in during this entry
      playground_pkg::word_t                 expected;   // Pins: [15:8] dir, [7:0] out
   } entry_t;

   logic                                  clk;
   logic                                  reset_button;
   playground_pkg::mem_req_t              mem_req;
   logic [playground_pkg::DATA_W-1:0]     mem_rdata;
   logic [playground_pkg::GPIO_W-1:0]     gpio_in;
   logic [playground_pkg::GPIO_W-1:0]     gpio_out;
   logic [playground_pkg::GPIO_W-1:0]     gpio_dir;
   playground_pkg::rgb_t                  led;
   logic                                  interrupt;

   // Scoreboard state
   playground_pkg::word_t                 ram_model [playground_pkg::RAM_WORDS];
   logic [playground_pkg::GPIO_W-1:0]     port_out_m;
   logic [playground_pkg::GPIO_W-1:0]     port_dir_m;
   logic [playground_pkg::GPIO_W-1:0]     gpio_in_m;
   entry_t                                stim_q [$];

   int cycle_count   = 0;
   int timeout_limit = 0;   // Zero until the table length is known

   periph_top dut_i (
      .clk          (clk),
      .reset_button (reset_button),
      .mem_req      (mem_req),
      .mem_rdata    (mem_rdata),
      .gpio_in      (gpio_in),
      .gpio_out     (gpio_out),
      .gpio_dir     (gpio_dir),
      .led          (led),
      .interrupt    (interrupt)
   );

   `include "tb_checks.svh"

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 100 ns period
   end

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (timeout_limit > 0 && cycle_count > timeout_limit)
      begin
         $display("timeout after %0d cycles, the test did not finish", cycle_count);
         $display("Something failed");
         $fatal(1, "timeout");
      end
   end

   task automatic wait_cycle;
      @(posedge clk);
      #1;
   endtask

   function automatic playground_pkg::word_t ram_addr(input int idx);
      return playground_pkg::word_t'(idx) << 2;   // Word index into RAM region
   endfunction

   function automatic playground_pkg::rgb_t make_rgb(input logic r, input logic g,
                                                     input logic b);
      playground_pkg::rgb_t v;
      v.red   = r;
      v.green = g;
      v.blue  = b;
      return v;
   endfunction

   // Register value after a modify mode, bits 3..2 of the address
   function automatic logic [7:0] apply_mode(input logic [1:0] op, input logic [7:0] live,
                                             input logic [7:0] data);
      case (op)
         2'd1:    return live & ~data;   // Clear
         2'd2:    return live | data;    // Set
         2'd3:    return live ^ data;    // Toggle
         default: return data;
      endcase
   endfunction

   function automatic playground_pkg::word_t expect_read(input playground_pkg::word_t addr);
      playground_pkg::word_t v;
      v = '0;
      if (addr[31:28] == 4'h0) v = ram_model[addr[11:2]];
      else if (addr[31:28] == 4'h4)
      begin
         if (addr[playground_pkg::IO_BIT_PORT_IN])  v |= 32'(gpio_in_m);
         if (addr[playground_pkg::IO_BIT_PORT_OUT]) v |= 32'(port_out_m);
         if (addr[playground_pkg::IO_BIT_PORT_DIR]) v |= 32'(port_dir_m);
      end
      return v;   // Unmapped nibbles read zero
   endfunction

   function automatic entry_t make_entry(input tb_op_e op, input playground_pkg::word_t addr,
                                         input playground_pkg::word_t data,
                                         input logic [3:0] mask,
                                         input playground_pkg::word_t expected);
      entry_t e;
      e.op       = op;
      e.addr     = addr;
      e.data     = data;
      e.mask     = mask;
      e.gpio     = gpio_in_m;
      e.expected = expected;
      return e;
   endfunction

   task automatic add_write(input playground_pkg::word_t addr, input playground_pkg::word_t data,
                            input logic [3:0] mask);
      stim_q.push_back(make_entry(OP_WRITE, addr, data, mask, '0));
      if (addr[31:28] == 4'h0)
      begin
         for (int lane = 0; lane < 4; lane++)
            if (mask[lane]) ram_model[addr[11:2]][8*lane +: 8] = data[8*lane +: 8];
      end
      else if (addr[31:28] == 4'h4 && mask[0])   // GPIO registers live in byte 0
      begin
         if (addr[playground_pkg::IO_BIT_PORT_OUT])
            port_out_m = apply_mode(addr[3:2], port_out_m, data[7:0]);
         if (addr[playground_pkg::IO_BIT_PORT_DIR])
            port_dir_m = apply_mode(addr[3:2], port_dir_m, data[7:0]);
      end
   endtask

   task automatic add_read(input playground_pkg::word_t addr);
      stim_q.push_back(make_entry(OP_READ, addr, '0, '0, expect_read(addr)));
   endtask

   task automatic add_pins;
      stim_q.push_back(make_entry(OP_PINS, '0, '0, '0, {16'h0, port_dir_m, port_out_m}));
   endtask

   task automatic build_table;
      int                    idx [8];
      logic [3:0]            part_mask [6];
      playground_pkg::word_t reg_addr;
      idx       = '{0, 1, 2, 5, 100, 511, 512, 1023};
      part_mask = '{4'b0001, 4'b0010, 4'b1100, 4'b0011, 4'b0100, 4'b1000};
      add_pins();                                       // Zero out of reset
      for (int i = 0; i < 8; i++) add_write(ram_addr(idx[i]), $urandom, 4'hf);
      for (int i = 0; i < 6; i++) add_write(ram_addr(idx[i]), $urandom, part_mask[i]);
      add_write(32'h3000_0000 | ram_addr(idx[7]), $urandom, 4'hf);   // Must not reach RAM
      for (int i = 0; i < 8; i++) add_read(ram_addr(idx[i]));
      add_read(32'h3000_0010);                          // Unmapped nibble
      for (int r = 0; r < 2; r++)
      begin
         reg_addr = (r == 0) ? PORT_OUT_ADDR : PORT_DIR_ADDR;
         for (int op = 0; op < 4; op++)                 // Write, clear, set, toggle
         begin
            add_write(reg_addr + 32'(4 * op), $urandom, 4'hf);
            add_read(reg_addr);
            add_pins();
         end
         add_write(reg_addr, $urandom, 4'b1110);        // Byte 0 masked off
         add_read(reg_addr);
         add_pins();
      end
      for (int i = 0; i < 4; i++)
      begin
         gpio_in_m = $urandom;
         add_read(PORT_IN_ADDR);
      end
      add_read(PORT_IN_ADDR | PORT_OUT_ADDR);           // Two selects OR together
      stim_q.push_back(make_entry(OP_WAIT, '0, '0, '0, '0));
   endtask

   task automatic run_table;
      entry_t                e;
      playground_pkg::word_t got;
      foreach (stim_q[i])
      begin
         e       = stim_q[i];
         gpio_in = e.gpio;
         case (e.op)
            OP_WRITE: bus_write(e.addr, e.data, e.mask);
            OP_READ:
            begin
               bus_read(e.addr, got);
               check_word($sformatf("mem_rdata at %h", e.addr), got, e.expected);
            end
            OP_PINS:
            begin
               check_gpio("gpio_out", gpio_out, e.expected[7:0]);
               check_gpio("gpio_dir", gpio_dir, e.expected[15:8]);
            end
            default: wait_cycle();
         endcase
      end
   endtask

   // Interrupt one cycle after ticks is all ones, then counting from reload
   task automatic run_timer;
      playground_pkg::word_t reload_val;
      playground_pkg::word_t exp_ticks;
      playground_pkg::word_t got;
      int                    start;
      reload_val = 32'h100 + ($urandom % 32'h100);
      bus_write(RELOAD_ADDR, reload_val, 4'hf);
      bus_write(TICKS_ADDR, 32'(0) - TICKS_GAP, 4'hf);
      start = cycle_count;                              // Cycle after the write
      for (int k = 0; k < 8; k++)
      begin
         check_bit("interrupt", interrupt, k == TICKS_GAP);
         wait_cycle();
      end
      exp_ticks = reload_val + 32'(cycle_count - start - TICKS_GAP);   // Value in strobe cycle
      bus_read(TICKS_ADDR, got);
      check_word("ticks", got, exp_ticks);
      bus_read(RELOAD_ADDR, got);
      check_word("reload", got, reload_val);
   endtask

   task automatic run_leds;
      logic        red_hist [47];
      int unsigned k;
      int unsigned highs;
      bus_write(LEDS_ADDR, 32'h2, 4'hf);                // Direct green bit
      repeat (20)
      begin
         check_rgb("led", led, make_rgb(1'b0, 1'b1, 1'b0));
         wait_cycle();
      end
      k = 1 + ($urandom % 15);
      bus_write(SDM_RED_ADDR, k << 12, 4'hf);
      repeat (2) wait_cycle();                          // Level and carry settle
      for (int i = 0; i < 47; i++)
      begin
         red_hist[i] = led.red;
         check_bit("led.green", led.green, 1'b1);
         wait_cycle();
      end
      for (int w = 0; w + 16 <= 47; w++)                // Every 16 cycle window
      begin
         highs = 0;
         for (int i = w; i < w + 16; i++) highs += red_hist[i];
         check_word("led.red highs in 16 cycles", highs, k);
      end
      bus_write(SDM_RED_ADDR, 32'h0, 4'hf);
      bus_write(LEDS_ADDR, 32'h0, 4'hf);
      repeat (2) wait_cycle();
      repeat (20)
      begin
         check_rgb("led", led, make_rgb(1'b0, 1'b0, 1'b0));
         wait_cycle();
      end
   endtask

   initial
   begin
      void'($urandom(SEED));
      reset_button = 1'b1;
      mem_req      = '0;
      gpio_in      = '0;
      port_out_m   = '0;
      port_dir_m   = '0;
      gpio_in_m    = '0;
      build_table();
      timeout_limit = RESET_CYCLES + 2 * stim_q.size() + TIMER_WAIT + LED_WAIT;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset_button = 1'b0;
      check_rgb("led", led, make_rgb(1'b0, 1'b0, 1'b0));
      check_bit("interrupt", interrupt, 1'b0);
      run_table();
      run_timer();
      run_leds();
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

//--- src/periph_top.sv
/*
   Peripheral and memory side of the board computer. The CPU, or a testbench
   standing in for it, drives mem_req and reads mem_rdata one cycle after the
   read strobe. GPIO pins, the three LEDs and the timer interrupt come out here.
*/
`timescale 1ns/1ps
`default_nettype none

module periph_top (
   input  logic                                   clk,
   input  logic                                   reset_button,
   input  playground_pkg::mem_req_t               mem_req,
   output logic [playground_pkg::DATA_W-1:0]      mem_rdata,
   input  logic [playground_pkg::GPIO_W-1:0]      gpio_in,
   output logic [playground_pkg::GPIO_W-1:0]      gpio_out,
   output logic [playground_pkg::GPIO_W-1:0]      gpio_dir,
   output playground_pkg::rgb_t                   led,
   output logic                                   interrupt
);

   logic [playground_pkg::MASK_W-1:0] ram_wen;
   logic [playground_pkg::DATA_W-1:0] ram_rdata;
   logic [playground_pkg::DATA_W-1:0] io_rdata;
   playground_pkg::io_wr_t            io_wr;
   logic                              io_rstrb;
   logic [playground_pkg::DATA_W-1:0] ticks;       // Timer state for readback
   logic [playground_pkg::DATA_W-1:0] reload;
   playground_pkg::rgb_t              led_bits;    // Direct on bits
   playground_pkg::rgb_levels_t       levels;      // Brightness per channel

   bus_decode bus_decode_i (
      .clk       (clk),
      .mem_req   (mem_req),
      .ram_rdata (ram_rdata),
      .io_rdata  (io_rdata),
      .ram_wen   (ram_wen),
      .io_wr     (io_wr),
      .io_rstrb  (io_rstrb),
      .mem_rdata (mem_rdata)
   );

   word_ram word_ram_i (
      .clk     (clk),
      .ram_wen (ram_wen),
      .addr    (mem_req.addr[playground_pkg::RAM_LSB +: playground_pkg::RAM_AW]),
      .wdata   (mem_req.wdata),
      .rdata   (ram_rdata)
   );

   io_regs io_regs_i (
      .clk          (clk),
      .reset_button (reset_button),
      .io_wr        (io_wr),
      .io_rstrb     (io_rstrb),
      .io_sel_rd    (mem_req.addr[playground_pkg::IO_SEL_HI:playground_pkg::IO_SEL_LO]),
      .gpio_in      (gpio_in),
      .ticks        (ticks),
      .reload       (reload),
      .io_rdata     (io_rdata),
      .gpio_out     (gpio_out),
      .gpio_dir     (gpio_dir),
      .led_bits     (led_bits),
      .levels       (levels)
   );

   interval_timer interval_timer_i (
      .clk          (clk),
      .reset_button (reset_button),
      .io_wr        (io_wr),
      .ticks        (ticks),
      .reload       (reload),
      .interrupt    (interrupt)
   );

   led_sdm led_sdm_i (
      .clk          (clk),
      .reset_button (reset_button),
      .levels       (levels),
      .led_bits     (led_bits),
      .led          (led)
   );

endmodule

`default_nettype wire

//--- src/led_sdm.sv
/*
   First-order sigma-delta brightness for the red, green and blue LEDs. Each
   channel adds its level to a phase accumulator, the registered carry lights
   the LED, and the direct on bit forces it on.
*/
`timescale 1ns/1ps
`default_nettype none

module led_sdm (
   input  logic                        clk,
   input  logic                        reset_button,
   input  playground_pkg::rgb_levels_t levels,
   input  playground_pkg::rgb_t        led_bits,
   output playground_pkg::rgb_t        led
);

   // Channel 2 is red, 1 green, 0 blue, same order as the structs
   logic [2:0][playground_pkg::SDM_W-1:0] level;
   logic [2:0][playground_pkg::SDM_W-1:0] phase;
   logic [2:0]                            carry;   // Modulator outputs

   assign level = {levels.red, levels.green, levels.blue};

   always_ff @(posedge clk)
   begin
      if (reset_button)
      begin
         phase <= '0;
         carry <= '0;
      end
      else
      begin
         for (int ch = 0; ch < 3; ch++)
         begin
            {carry[ch], phase[ch]} <= {1'b0, phase[ch]} + {1'b0, level[ch]};
         end
      end
   end

   assign led = playground_pkg::rgb_t'(carry | led_bits);   // Direct bit ORed in

endmodule

`default_nettype wire

//--- src/interval_timer.sv
/*
   Free-running 32-bit tick counter. On wrap it restarts from the reload value
   and raises a one-cycle interrupt pulse. Both registers are written through
   the I/O page with plain data, no modify mode.
*/
`timescale 1ns/1ps
`default_nettype none

module interval_timer (
   input  logic                              clk,
   input  logic                              reset_button,
   input  playground_pkg::io_wr_t            io_wr,
   output logic [playground_pkg::DATA_W-1:0] ticks,
   output logic [playground_pkg::DATA_W-1:0] reload,
   output logic                              interrupt
);

   logic [playground_pkg::DATA_W:0] ticks_plus_1;   // Top bit flags the wrap
   logic                            wr_ticks;
   logic                            wr_reload;

   assign ticks_plus_1 = {1'b0, ticks} + 1'b1;
   assign wr_ticks     = io_wr.strb
                         & io_wr.sel[playground_pkg::IO_BIT_TICKS - playground_pkg::IO_SEL_LO];
   assign wr_reload    = io_wr.strb
                         & io_wr.sel[playground_pkg::IO_BIT_RELOAD - playground_pkg::IO_SEL_LO];

   always_ff @(posedge clk)
   begin
      if (reset_button)
      begin
         ticks     <= '0;
         reload    <= '0;
         interrupt <= 1'b0;
      end
      else
      begin
         if (wr_ticks) ticks <= io_wr.wdata;   // CPU write wins over counting
         else if (ticks_plus_1[playground_pkg::DATA_W]) ticks <= reload;
         else ticks <= ticks_plus_1[playground_pkg::DATA_W-1:0];
         if (wr_reload) reload <= io_wr.wdata;
         interrupt <= ticks_plus_1[playground_pkg::DATA_W];   // High the cycle after all ones
      end
   end

endmodule

`default_nettype wire

//--- src/io_regs.sv
/*
   One-hot I/O register page. Each address bit 19..4 selects one register, and
   bits 3..2 pick write, clear, set or toggle against the live value. The read
   value is captured on the read strobe so the CPU sees the strobe-cycle state.
*/
`timescale 1ns/1ps
`default_nettype none

module io_regs (
   input  logic                                clk,
   input  logic                                reset_button,
   input  playground_pkg::io_wr_t              io_wr,
   input  logic                                io_rstrb,
   input  logic [playground_pkg::IO_SEL_W-1:0] io_sel_rd,
   input  logic [playground_pkg::GPIO_W-1:0]   gpio_in,
   input  logic [playground_pkg::DATA_W-1:0]   ticks,
   input  logic [playground_pkg::DATA_W-1:0]   reload,
   output logic [playground_pkg::DATA_W-1:0]   io_rdata,
   output logic [playground_pkg::GPIO_W-1:0]   gpio_out,
   output logic [playground_pkg::GPIO_W-1:0]   gpio_dir,
   output playground_pkg::rgb_t                led_bits,
   output playground_pkg::rgb_levels_t         levels
);

   playground_pkg::word_t rd_hot;    // Read select, lined up with address bits
   playground_pkg::word_t wr_hot;    // Write select, only during an I/O write
   playground_pkg::word_t io_live;   // OR of every selected register
   playground_pkg::word_t io_mod;    // Live value after the modify mode
   playground_pkg::word_t wval;      // Value that lands in the register

   assign rd_hot = playground_pkg::word_t'(io_sel_rd) << playground_pkg::IO_SEL_LO;
   assign wr_hot = io_wr.strb
                   ? playground_pkg::word_t'(io_wr.sel) << playground_pkg::IO_SEL_LO
                   : '0;

   always_comb
   begin
      io_live = '0;
      if (rd_hot[playground_pkg::IO_BIT_PORT_IN])
         io_live |= playground_pkg::word_t'(gpio_in);                  // R  GPIO pins
      if (rd_hot[playground_pkg::IO_BIT_PORT_OUT])
         io_live |= playground_pkg::word_t'(gpio_out);                 // RW GPIO out
      if (rd_hot[playground_pkg::IO_BIT_PORT_DIR])
         io_live |= playground_pkg::word_t'(gpio_dir);                 // RW GPIO dir
      if (rd_hot[playground_pkg::IO_BIT_LEDS])                         // RW [2:0] b g r
         io_live |= playground_pkg::word_t'({led_bits.blue, led_bits.green, led_bits.red});
      if (rd_hot[playground_pkg::IO_BIT_SDM_RED])
         io_live |= playground_pkg::word_t'(levels.red);
      if (rd_hot[playground_pkg::IO_BIT_SDM_GREEN])
         io_live |= playground_pkg::word_t'(levels.green);
      if (rd_hot[playground_pkg::IO_BIT_SDM_BLUE])
         io_live |= playground_pkg::word_t'(levels.blue);
      if (rd_hot[playground_pkg::IO_BIT_TICKS])  io_live |= ticks;    // Timer count
      if (rd_hot[playground_pkg::IO_BIT_RELOAD]) io_live |= reload;   // Timer reload
   end

   // Write +0, clear +4, set +8, toggle +12
   always_comb
   begin
      case (io_wr.op)
         playground_pkg::IO_CLEAR:  io_mod = io_live & ~io_wr.wdata;
         playground_pkg::IO_SET:    io_mod = io_live | io_wr.wdata;
         playground_pkg::IO_TOGGLE: io_mod = io_live ^ io_wr.wdata;
         default:                   io_mod = io_wr.wdata;
      endcase
   end

   // Lanes outside the write mask keep their live bytes
   always_comb
   begin
      for (int lane = 0; lane < playground_pkg::MASK_W; lane++)
      begin
         wval[8*lane +: 8] = io_wr.wmask[lane] ? io_mod[8*lane +: 8] : io_live[8*lane +: 8];
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset_button)
      begin
         gpio_out <= '0;
         gpio_dir <= '0;
         led_bits <= '0;
         levels   <= '0;   // All modulators off
      end
      else
      begin
         if (wr_hot[playground_pkg::IO_BIT_PORT_OUT]) gpio_out <= wval[playground_pkg::GPIO_W-1:0];
         if (wr_hot[playground_pkg::IO_BIT_PORT_DIR]) gpio_dir <= wval[playground_pkg::GPIO_W-1:0];
         if (wr_hot[playground_pkg::IO_BIT_LEDS])
         begin
            led_bits.red   <= wval[0];
            led_bits.green <= wval[1];
            led_bits.blue  <= wval[2];
         end
         if (wr_hot[playground_pkg::IO_BIT_SDM_RED])
            levels.red <= wval[playground_pkg::SDM_W-1:0];
         if (wr_hot[playground_pkg::IO_BIT_SDM_GREEN])
            levels.green <= wval[playground_pkg::SDM_W-1:0];
         if (wr_hot[playground_pkg::IO_BIT_SDM_BLUE])
            levels.blue <= wval[playground_pkg::SDM_W-1:0];
      end
   end

   // Read value as it was in the strobe cycle
   always_ff @(posedge clk)
   begin
      if (io_rstrb) io_rdata <= io_live;
   end

endmodule

`default_nettype wire

//--- src/word_ram.sv
/*
   Word RAM with byte lane write enables. Reads are registered every cycle,
   so data for an address shows up one clock later.
*/
`timescale 1ns/1ps
`default_nettype none

module word_ram (
   input  logic                              clk,
   input  logic [playground_pkg::MASK_W-1:0] ram_wen,
   input  logic [playground_pkg::RAM_AW-1:0] addr,    // Word index
   input  logic [playground_pkg::DATA_W-1:0] wdata,
   output logic [playground_pkg::DATA_W-1:0] rdata
);

   logic [playground_pkg::DATA_W-1:0] mem [playground_pkg::RAM_WORDS];

   always_ff @(posedge clk)
   begin
      for (int lane = 0; lane < playground_pkg::MASK_W; lane++)
      begin
         if (ram_wen[lane]) mem[addr][8*lane +: 8] <= wdata[8*lane +: 8];  // Byte lane write
      end
      rdata <= mem[addr];   // Old word on a same-cycle write
   end

endmodule

`default_nettype wire

//--- src/bus_decode.sv
/*
   Memory map decoder. Splits the bus into the RAM write enables and the I/O
   write and read strobes, and steers the read data of the addressed region
   back onto mem_rdata in the cycle after the read strobe.
*/
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
   input  logic                              clk,
   input  playground_pkg::mem_req_t          mem_req,
   input  logic [playground_pkg::DATA_W-1:0] ram_rdata,
   input  logic [playground_pkg::DATA_W-1:0] io_rdata,
   output logic [playground_pkg::MASK_W-1:0] ram_wen,
   output playground_pkg::io_wr_t            io_wr,
   output logic                              io_rstrb,
   output logic [playground_pkg::DATA_W-1:0] mem_rdata
);

   playground_pkg::region_e region;      // Region of the current address
   playground_pkg::region_e rd_region;   // Region of the pending read

   always_comb
   begin
      case (mem_req.addr[playground_pkg::ADDR_W-1 -: playground_pkg::REGION_W])
         4'h0:    region = playground_pkg::REGION_RAM;    // 0x0000_0000
         4'h4:    region = playground_pkg::REGION_IO;     // 0x4000_0000
         default: region = playground_pkg::REGION_NONE;
      endcase
   end

   assign ram_wen = mem_req.wmask
                    & {playground_pkg::MASK_W{region == playground_pkg::REGION_RAM}};

   // I/O write carries the one-hot select and the modify mode from the address
   assign io_wr.strb  = (|mem_req.wmask) & (region == playground_pkg::REGION_IO);
   assign io_wr.sel   = mem_req.addr[playground_pkg::IO_SEL_HI:playground_pkg::IO_SEL_LO];
   assign io_wr.op    = playground_pkg::io_op_e'(
                           mem_req.addr[playground_pkg::IO_OP_LSB +: $bits(io_wr.op)]);
   assign io_wr.wdata = mem_req.wdata;
   assign io_wr.wmask = mem_req.wmask;

   assign io_rstrb = mem_req.rstrb & (region == playground_pkg::REGION_IO);

   // Remember which region the read went to, data comes back next cycle
   always_ff @(posedge clk)
   begin
      if (mem_req.rstrb) rd_region <= region;
   end

   always_comb
   begin
      case (rd_region)
         playground_pkg::REGION_RAM: mem_rdata = ram_rdata;
         playground_pkg::REGION_IO:  mem_rdata = io_rdata;   // Buffered at the strobe
         default:                    mem_rdata = '0;         // Unmapped reads zero
      endcase
   end

endmodule

`default_nettype wire

//--- src/playground_pkg.sv
/*
   Shared widths, memory map, I/O page bit positions and bus types for the
   peripheral side of the playground board. Every module and the testbench
   reach these by scoped names.
*/
`default_nettype none

package playground_pkg;

   // Bus geometry
   localparam int ADDR_W   = 32;
   localparam int DATA_W   = 32;
   localparam int MASK_W   = DATA_W / 8;   // One write enable per byte lane
   localparam int REGION_W = 4;            // Top address nibble picks the region

   // Word RAM, indexed by address bits 11 to 2
   localparam int RAM_WORDS = 1024;
   localparam int RAM_AW    = $clog2(RAM_WORDS);
   localparam int RAM_LSB   = 2;

   // I/O page, one-hot register select on the address
   localparam int IO_OP_LSB        = 2;    // Modify mode sits in bits 3..2
   localparam int IO_BIT_PORT_IN   = 4;
   localparam int IO_BIT_PORT_OUT  = 5;
   localparam int IO_BIT_PORT_DIR  = 6;
   localparam int IO_BIT_LEDS      = 8;
   localparam int IO_BIT_SDM_RED   = 9;
   localparam int IO_BIT_SDM_GREEN = 10;
   localparam int IO_BIT_SDM_BLUE  = 11;
   localparam int IO_BIT_TICKS     = 18;
   localparam int IO_BIT_RELOAD    = 19;
   localparam int IO_SEL_LO        = IO_BIT_PORT_IN;
   localparam int IO_SEL_HI        = IO_BIT_RELOAD;
   localparam int IO_SEL_W         = IO_SEL_HI - IO_SEL_LO + 1;

   localparam int GPIO_W = 8;
   localparam int SDM_W  = 16;   // Sigma-delta level and phase width

   typedef logic [DATA_W-1:0] word_t;

   typedef enum logic [REGION_W-1:0] {
      REGION_RAM  = 4'h0,
      REGION_IO   = 4'h4,
      REGION_NONE = 4'hf   // Stands for every unmapped nibble
   } region_e;

   typedef enum logic [1:0] {
      IO_WRITE  = 2'd0,
      IO_CLEAR  = 2'd1,
      IO_SET    = 2'd2,
      IO_TOGGLE = 2'd3
   } io_op_e;

   // One bus cycle as the CPU drives it
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [MASK_W-1:0] wmask;   // Non-zero means write
      logic              rstrb;   // One-cycle read request
   } mem_req_t;

   // I/O write as handed on by the decoder
   typedef struct packed {
      logic                strb;
      logic [IO_SEL_W-1:0] sel;   // Address bits 19..4
      io_op_e              op;
      logic [DATA_W-1:0]   wdata;
      logic [MASK_W-1:0]   wmask;
   } io_wr_t;

   typedef struct packed {
      logic [SDM_W-1:0] red;
      logic [SDM_W-1:0] green;
      logic [SDM_W-1:0] blue;
   } rgb_levels_t;

   typedef struct packed {
      logic red;
      logic green;
      logic blue;
   } rgb_t;

endpackage

`default_nettype wire
